// ==== design/img_pkg.sv ====
`default_nettype none

package img_pkg;

   // command bytes on the link
   localparam logic [7:0] CMD_PARAM           = 8'd0;
   localparam logic [7:0] CMD_SEND_IMG        = 8'd1;
   localparam logic [7:0] CMD_READ_IMG        = 8'd2;
   localparam logic [7:0] CMD_GET_STATUS      = 8'd3;
   localparam logic [7:0] CMD_APPLY_ADD       = 8'd4;
   localparam logic [7:0] CMD_APPLY_THRESHOLD = 8'd5;
   localparam logic [7:0] CMD_SWITCH_BUFFERS  = 8'd6;
   localparam logic [7:0] CMD_APPLY_INVERT    = 8'd8;
   localparam logic [7:0] CMD_APPLY_MULT      = 8'd14;

   // pixel operation select
   localparam logic [1:0] OP_ADD       = 2'd0;
   localparam logic [1:0] OP_THRESHOLD = 2'd1;
   localparam logic [1:0] OP_INVERT    = 2'd2;
   localparam logic [1:0] OP_MULT      = 2'd3;

   localparam int ADDR_W  = 32;  // byte address
   localparam int WORD_W  = 16;  // two pixels, low byte first
   localparam int PIXEL_W = 8;
   localparam int DIM_W   = 16;

   // small second buffer, enough for simulation images
   localparam logic [ADDR_W-1:0] BUFFER2_LOCATION = 32'd512;

   localparam logic [7:0] STATUS_BYTE0 = 8'h11;  // bit 0 carries busy
   localparam logic [7:0] STATUS_BYTE1 = 8'h22;
   localparam logic [7:0] STATUS_BYTE2 = 8'h33;
   localparam logic [7:0] STATUS_BYTE3 = 8'h44;

   localparam int FRAC_BITS = 4;  // fixed-point fraction of mult result

endpackage

`default_nettype wire

// ==== design/command_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module command_decoder import img_pkg::*; (
   input  wire logic               clk,
   input  wire logic               reset,
   input  wire logic [7:0]         comm_cmd,
   input  wire logic [7:0]         comm_data_in,
   input  wire logic               comm_data_in_valid,
   input  wire logic               proc_busy,
   output logic                    dec_wr,
   output logic [ADDR_W-1:0]       dec_addr,
   output logic [WORD_W-1:0]       dec_data,
   output logic                    proc_start,
   output logic [1:0]              op,
   output logic [DIM_W-1:0]        pixel_count,
   output logic [ADDR_W-1:0]       proc_base,
   output logic [DIM_W-1:0]        add_value,
   output logic                    clamp,
   output logic [PIXEL_W-1:0]      thr_value,
   output logic [PIXEL_W-1:0]      thr_replace,
   output logic                    thr_upper,
   output logic [PIXEL_W-1:0]      mult_value,
   output logic                    read_start,
   output logic [ADDR_W-1:0]       read_base,
   output logic                    status_start
);

   logic               active;   // collecting bytes for cur_cmd
   logic [7:0]         cur_cmd;
   logic [DIM_W-1:0]   cnt;      // bytes taken since the command
   logic [ADDR_W-1:0]  wr_addr;
   logic [PIXEL_W-1:0] lo_byte;
   logic [DIM_W-1:0]   img_width;
   logic [DIM_W-1:0]   img_height;
   logic [ADDR_W-1:0]  input_base;
   logic [ADDR_W-1:0]  storage_base;
   logic               blocked;

   assign pixel_count = DIM_W'(img_width * img_height);
   assign proc_base   = storage_base;
   assign read_base   = input_base;
   // proc_start covers the cycle before busy shows up
   assign blocked     = proc_busy | proc_start;

   always_ff @(posedge clk) begin
      dec_wr       <= 1'b0;
      proc_start   <= 1'b0;
      read_start   <= 1'b0;
      status_start <= 1'b0;
      if (reset) begin
         active       <= 1'b0;
         img_width    <= '0;
         img_height   <= '0;
         input_base   <= '0;
         storage_base <= BUFFER2_LOCATION;
      end else if (comm_data_in_valid && !active) begin
         cnt     <= '0;
         cur_cmd <= comm_cmd;
         wr_addr <= input_base;
         if (comm_cmd == CMD_GET_STATUS) begin
            status_start <= 1'b1;   // allowed while busy
         end else if (!blocked) begin
            case (comm_cmd)
               CMD_PARAM: begin
                  active       <= 1'b1;
                  input_base   <= '0;
                  storage_base <= BUFFER2_LOCATION;
               end
               CMD_SEND_IMG, CMD_APPLY_ADD, CMD_APPLY_THRESHOLD, CMD_APPLY_MULT:
                  active <= 1'b1;
               CMD_READ_IMG: read_start <= 1'b1;
               CMD_SWITCH_BUFFERS: begin
                  input_base   <= storage_base;
                  storage_base <= input_base;
               end
               CMD_APPLY_INVERT: begin
                  op         <= OP_INVERT;
                  proc_start <= 1'b1;
               end
               default: ;
            endcase
         end
      end else if (comm_data_in_valid) begin
         cnt <= cnt + 1'b1;
         case (cur_cmd)
            CMD_PARAM: begin
               // width then height, low byte first
               case (cnt[1:0])
                  2'd0: img_width[7:0]   <= comm_data_in;
                  2'd1: img_width[15:8]  <= comm_data_in;
                  2'd2: img_height[7:0]  <= comm_data_in;
                  default: begin
                     img_height[15:8] <= comm_data_in;
                     active           <= 1'b0;
                  end
               endcase
            end
            CMD_SEND_IMG: begin
               wr_addr <= wr_addr + 1'b1;
               if (!wr_addr[0]) begin
                  lo_byte <= comm_data_in;
               end else begin
                  dec_wr   <= 1'b1;   // full word on each odd byte
                  dec_addr <= {wr_addr[ADDR_W-1:1], 1'b0};
                  dec_data <= {comm_data_in, lo_byte};
               end
               if (cnt == pixel_count - 1'b1)
                  active <= 1'b0;
            end
            CMD_APPLY_ADD: begin
               case (cnt[1:0])
                  2'd0: add_value[7:0]  <= comm_data_in;
                  2'd1: add_value[15:8] <= comm_data_in;
                  default: begin
                     clamp      <= comm_data_in[0];
                     op         <= OP_ADD;
                     proc_start <= 1'b1;
                     active     <= 1'b0;
                  end
               endcase
            end
            CMD_APPLY_THRESHOLD: begin
               case (cnt[1:0])
                  2'd0: thr_value   <= comm_data_in;
                  2'd1: thr_replace <= comm_data_in;
                  default: begin
                     thr_upper  <= comm_data_in[0];
                     op         <= OP_THRESHOLD;
                     proc_start <= 1'b1;
                     active     <= 1'b0;
                  end
               endcase
            end
            default: begin   // mult: factor, then clamp flag
               if (cnt[0] == 1'b0) begin
                  mult_value <= comm_data_in;
               end else begin
                  clamp      <= comm_data_in[0];
                  op         <= OP_MULT;
                  proc_start <= 1'b1;
                  active     <= 1'b0;
               end
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== design/memory_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module memory_port import img_pkg::*; (
   input  wire logic              clk,
   input  wire logic              reset,
   input  wire logic              dec_wr,
   input  wire logic [ADDR_W-1:0] dec_addr,
   input  wire logic [WORD_W-1:0] dec_data,
   input  wire logic              proc_rd,
   input  wire logic              proc_wr,
   input  wire logic [ADDR_W-1:0] proc_addr,
   input  wire logic [WORD_W-1:0] proc_data,
   input  wire logic              stream_rd,
   input  wire logic [ADDR_W-1:0] stream_addr,
   output logic [ADDR_W-1:0]      addr,
   output logic                   rd_en,
   output logic                   wr_en,
   output logic [WORD_W-1:0]      data_write,
   input  wire logic              data_read_valid,
   output logic                   proc_rd_valid,
   output logic                   stream_rd_valid
);

   logic rd_owner_proc;   // who issued the last read

   always_ff @(posedge clk) begin
      if (dec_wr) begin
         addr       <= dec_addr;
         data_write <= dec_data;
      end else if (proc_rd || proc_wr) begin
         addr       <= proc_addr;
         data_write <= proc_data;
      end else if (stream_rd) begin
         addr <= stream_addr;
      end

      if (reset) begin
         rd_en         <= 1'b0;
         wr_en         <= 1'b0;
         rd_owner_proc <= 1'b0;
      end else begin
         rd_en <= proc_rd | stream_rd;
         wr_en <= dec_wr | proc_wr;
         if (proc_rd)
            rd_owner_proc <= 1'b1;
         else if (stream_rd)
            rd_owner_proc <= 1'b0;
      end
   end

   assign proc_rd_valid   = data_read_valid & rd_owner_proc;
   assign stream_rd_valid = data_read_valid & ~rd_owner_proc;

   // the three requesters never overlap
   a_one_requester: assert property (@(posedge clk) disable iff (reset)
      $onehot0({dec_wr, proc_rd, proc_wr, stream_rd}));

endmodule

`default_nettype wire

// ==== design/pixel_op_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_op_unit import img_pkg::*; (
   input  wire logic [1:0]         op,
   input  wire logic [PIXEL_W-1:0] pixel_in,
   input  wire logic [DIM_W-1:0]   add_value,
   input  wire logic               clamp,
   input  wire logic [PIXEL_W-1:0] thr_value,
   input  wire logic [PIXEL_W-1:0] thr_replace,
   input  wire logic               thr_upper,
   input  wire logic [PIXEL_W-1:0] mult_value,
   output logic [PIXEL_W-1:0]      pixel_out
);

   logic [WORD_W-1:0] sum;
   logic [WORD_W-1:0] prod;
   logic [WORD_W-1:0] scaled;
   logic              thr_hit;

   // low byte, or saturate to 0..255 when reading v as signed
   function automatic logic [PIXEL_W-1:0] clamp_byte(input logic [WORD_W-1:0] v,
                                                     input logic en);
      if (en && $signed(v) > 255)
         return 8'hff;
      else if (en && $signed(v) < 0)
         return 8'h00;
      else
         return v[PIXEL_W-1:0];
   endfunction

   assign sum    = {8'b0, pixel_in} + add_value;
   assign prod   = pixel_in * mult_value;              // 8x8 unsigned
   assign scaled = WORD_W'($signed(prod) >>> FRAC_BITS);   // bits 15..4, sign kept
   assign thr_hit = thr_upper ? (pixel_in >= thr_value) : (pixel_in <= thr_value);

   always_comb begin
      case (op)
         OP_ADD:       pixel_out = clamp_byte(sum, clamp);
         OP_THRESHOLD: pixel_out = thr_hit ? thr_replace : pixel_in;
         OP_INVERT:    pixel_out = ~pixel_in;
         default:      pixel_out = clamp_byte(scaled, clamp);
      endcase
   end

endmodule

`default_nettype wire

// ==== design/pixel_processor.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_processor import img_pkg::*; (
   input  wire logic               clk,
   input  wire logic               reset,
   input  wire logic               proc_start,
   input  wire logic [1:0]         op,
   input  wire logic [DIM_W-1:0]   pixel_count,
   input  wire logic [ADDR_W-1:0]  proc_base,
   input  wire logic [DIM_W-1:0]   add_value,
   input  wire logic               clamp,
   input  wire logic [PIXEL_W-1:0] thr_value,
   input  wire logic [PIXEL_W-1:0] thr_replace,
   input  wire logic               thr_upper,
   input  wire logic [PIXEL_W-1:0] mult_value,
   input  wire logic               proc_rd_valid,
   input  wire logic [WORD_W-1:0]  data_read,
   output logic                    proc_rd,
   output logic                    proc_wr,
   output logic [ADDR_W-1:0]       proc_addr,
   output logic [WORD_W-1:0]       proc_data,
   output logic                    proc_busy
);

   logic               waiting;    // read out, valid not yet back
   logic [DIM_W-1:0]   remaining;
   logic [ADDR_W-1:0]  word_addr;
   logic [PIXEL_W-1:0] lo_out;
   logic [PIXEL_W-1:0] hi_out;

   pixel_op_unit u_lo (
      .op, .pixel_in(data_read[7:0]), .add_value, .clamp, .thr_value, .thr_replace,
      .thr_upper, .mult_value, .pixel_out(lo_out)
   );

   pixel_op_unit u_hi (
      .op, .pixel_in(data_read[15:8]), .add_value, .clamp, .thr_value, .thr_replace,
      .thr_upper, .mult_value, .pixel_out(hi_out)
   );

   always_ff @(posedge clk) begin
      proc_rd <= 1'b0;
      proc_wr <= 1'b0;
      if (reset) begin
         proc_busy <= 1'b0;
         waiting   <= 1'b0;
      end else if (proc_start) begin
         proc_busy <= 1'b1;
         waiting   <= 1'b0;
         remaining <= pixel_count;
         word_addr <= proc_base;
      end else if (proc_busy) begin
         if (proc_wr) begin
            if (remaining == '0)
               proc_busy <= 1'b0;   // drops right after the last write
         end else if (!waiting) begin
            proc_rd   <= 1'b1;
            proc_addr <= word_addr;
            waiting   <= 1'b1;
         end else if (proc_rd_valid) begin
            proc_wr   <= 1'b1;       // same address as the read
            proc_data <= {hi_out, lo_out};
            waiting   <= 1'b0;
            word_addr <= word_addr + ADDR_W'(2);
            remaining <= remaining - DIM_W'(2);
         end
      end
   end

   // decoder holds off memory commands until the sweep ends
   a_no_restart: assert property (@(posedge clk) disable iff (reset)
      proc_start |-> !proc_busy);

endmodule

`default_nettype wire

// ==== design/image_streamer.sv ====
`timescale 1ns/1ps
`default_nettype none

module image_streamer import img_pkg::*; (
   input  wire logic              clk,
   input  wire logic              reset,
   input  wire logic              read_start,
   input  wire logic [ADDR_W-1:0] read_base,
   input  wire logic [DIM_W-1:0]  pixel_count,
   input  wire logic              status_start,
   input  wire logic              proc_busy,
   input  wire logic              stream_rd_valid,
   input  wire logic [WORD_W-1:0] data_read,
   input  wire logic              comm_data_out_free,
   output logic                   stream_rd,
   output logic [ADDR_W-1:0]      stream_addr,
   output logic [7:0]             comm_data_out,
   output logic                   comm_data_out_valid
);

   logic              reading;
   logic              waiting;
   logic              have_word;
   logic              hi_next;      // low byte already sent
   logic [DIM_W-1:0]  remaining;
   logic [ADDR_W-1:0] rd_addr;
   logic [WORD_W-1:0] word;
   logic [2:0]        status_left;

   always_ff @(posedge clk) begin
      stream_rd           <= 1'b0;
      comm_data_out_valid <= 1'b0;
      if (reset) begin
         reading     <= 1'b0;
         waiting     <= 1'b0;
         have_word   <= 1'b0;
         status_left <= '0;
      end else begin
         if (status_start)
            status_left <= 3'd4;
         if (read_start) begin
            reading   <= 1'b1;
            waiting   <= 1'b0;
            have_word <= 1'b0;
            remaining <= pixel_count;
            rd_addr   <= read_base;
         end else if (reading && !waiting && !have_word) begin
            stream_rd   <= 1'b1;
            stream_addr <= rd_addr;
            rd_addr     <= rd_addr + ADDR_W'(2);
            waiting     <= 1'b1;
         end else if (waiting && stream_rd_valid) begin
            word      <= data_read;
            have_word <= 1'b1;
            hi_next   <= 1'b0;
            waiting   <= 1'b0;
         end

         // status takes the link first, readout holds its place meanwhile
         if (comm_data_out_free && status_left != '0) begin
            comm_data_out_valid <= 1'b1;
            status_left         <= status_left - 1'b1;
            case (status_left)
               3'd4:    comm_data_out <= {STATUS_BYTE0[7:1], proc_busy};
               3'd3:    comm_data_out <= STATUS_BYTE1;
               3'd2:    comm_data_out <= STATUS_BYTE2;
               default: comm_data_out <= STATUS_BYTE3;
            endcase
         end else if (comm_data_out_free && have_word) begin
            comm_data_out_valid <= 1'b1;
            comm_data_out       <= hi_next ? word[15:8] : word[7:0];
            hi_next             <= ~hi_next;
            remaining           <= remaining - 1'b1;
            if (hi_next)
               have_word <= 1'b0;
            if (remaining == DIM_W'(1)) begin
               reading   <= 1'b0;   // last byte of the image
               have_word <= 1'b0;
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== design/image_proc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module image_proc_top import img_pkg::*; (
   input  wire logic              clk,
   input  wire logic              reset,
   output logic [ADDR_W-1:0]      addr,
   output logic                   wr_en,
   output logic                   rd_en,
   input  wire logic [WORD_W-1:0] data_read,
   input  wire logic              data_read_valid,
   output logic [WORD_W-1:0]      data_write,
   input  wire logic [7:0]        comm_cmd,
   input  wire logic [7:0]        comm_data_in,
   input  wire logic              comm_data_in_valid,
   output logic [7:0]             comm_data_out,
   output logic                   comm_data_out_valid,
   input  wire logic              comm_data_out_free
);

   logic               dec_wr;
   logic [ADDR_W-1:0]  dec_addr;
   logic [WORD_W-1:0]  dec_data;
   logic               proc_start, clamp, thr_upper, read_start, status_start;
   logic [1:0]         op;
   logic [DIM_W-1:0]   pixel_count, add_value;
   logic [ADDR_W-1:0]  proc_base, read_base;
   logic [PIXEL_W-1:0] thr_value, thr_replace, mult_value;
   logic               proc_rd, proc_wr, proc_busy, proc_rd_valid;
   logic [ADDR_W-1:0]  proc_addr, stream_addr;
   logic [WORD_W-1:0]  proc_data;
   logic               stream_rd, stream_rd_valid;

   command_decoder u_decoder (
      .clk, .reset, .comm_cmd, .comm_data_in, .comm_data_in_valid, .proc_busy,
      .dec_wr, .dec_addr, .dec_data, .proc_start, .op, .pixel_count, .proc_base,
      .add_value, .clamp, .thr_value, .thr_replace, .thr_upper, .mult_value,
      .read_start, .read_base, .status_start
   );

   memory_port u_memory_port (
      .clk, .reset, .dec_wr, .dec_addr, .dec_data, .proc_rd, .proc_wr, .proc_addr,
      .proc_data, .stream_rd, .stream_addr, .addr, .rd_en, .wr_en, .data_write,
      .data_read_valid, .proc_rd_valid, .stream_rd_valid
   );

   pixel_processor u_processor (
      .clk, .reset, .proc_start, .op, .pixel_count, .proc_base, .add_value, .clamp,
      .thr_value, .thr_replace, .thr_upper, .mult_value, .proc_rd_valid, .data_read,
      .proc_rd, .proc_wr, .proc_addr, .proc_data, .proc_busy
   );

   image_streamer u_streamer (
      .clk, .reset, .read_start, .read_base, .pixel_count, .status_start, .proc_busy,
      .stream_rd_valid, .data_read, .comm_data_out_free, .stream_rd, .stream_addr,
      .comm_data_out, .comm_data_out_valid
   );

endmodule

`default_nettype wire

// ==== test/image_proc_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module image_proc_checker (
   input  wire logic       clk,
   input  wire logic       reset,
   input  wire logic [7:0] comm_data_out,
   input  wire logic       comm_data_out_valid,
   input  wire logic       exp_push,     // one expected byte per strobe
   input  wire logic [7:0] exp_byte,
   input  wire logic       test_end,
   input  wire logic [7:0] test_id,
   output int              pending,      // expected bytes not yet seen
   output int              checked,
   output int              errors
);

   logic [7:0] exp_q[$];
   logic [7:0] want;
   int         test_checked;
   int         test_errors;

   // mid-cycle sampling, link outputs are registered on the rising edge
   always @(negedge clk) begin
      if (reset) begin
         exp_q.delete();
         checked      = 0;
         errors       = 0;
         test_checked = 0;
         test_errors  = 0;
      end else begin
         if (exp_push)
            exp_q.push_back(exp_byte);
         if (comm_data_out_valid) begin
            if (exp_q.size() == 0) begin
               $display("test %0d: byte %h came out on comm_data_out when none was expected",
                        test_id, comm_data_out);
               errors++;
               test_errors++;
            end else begin
               want = exp_q.pop_front();
               checked++;
               test_checked++;
               if (comm_data_out !== want) begin
                  $display("CHECK FAILED test %0d byte %0d: comm_data_out = %h, expected %h",
                           test_id, test_checked - 1, comm_data_out, want);
                  errors++;
                  test_errors++;
               end
            end
         end
         if (test_end) begin
            if (exp_q.size() != 0) begin
               $display("test %0d: %0d expected bytes never came out on the link",
                        test_id, exp_q.size());
               errors      += exp_q.size();
               test_errors += exp_q.size();
               exp_q.delete();
            end
            $display("test %0d: %0d bytes checked, %0d errors", test_id, test_checked,
                     test_errors);
            test_checked = 0;
            test_errors  = 0;
         end
      end
      pending = exp_q.size();
   end

endmodule

`default_nettype wire

// ==== test/tb_image_proc.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_image_proc import img_pkg::*; ();

   localparam logic [31:0] SEED = 32'h79e942a2;
   localparam int WIDTH       = 8;
   localparam int HEIGHT      = 4;
   localparam int PIXELS      = WIDTH * HEIGHT;
   localparam int NUM_TESTS   = 8;
   localparam int WAIT_LIMIT  = 40 * PIXELS;   // cycles allowed for one test
   localparam int CYCLE_LIMIT = NUM_TESTS * WAIT_LIMIT + 2000;

   logic              clk;
   logic              reset;
   logic [ADDR_W-1:0] addr;
   logic              wr_en;
   logic              rd_en;
   logic [WORD_W-1:0] data_read;
   logic              data_read_valid;
   logic [WORD_W-1:0] data_write;
   logic [7:0]        comm_cmd;
   logic [7:0]        comm_data_in;
   logic              comm_data_in_valid;
   logic [7:0]        comm_data_out;
   logic              comm_data_out_valid;
   logic              comm_data_out_free;

   logic              exp_push;
   logic [7:0]        exp_byte;
   logic              test_end;
   logic [7:0]        test_id;
   int                pending;
   int                checked;
   int                errors;
   int                tests_run;
   int                cycles;

   logic [31:0]       rng_stim;
   logic [31:0]       rng_mem;
   logic [31:0]       rng_free;
   logic [WORD_W-1:0] mem [512];      // word memory, index is addr[9:1]
   logic [7:0]        img [PIXELS];   // model of the buffer at address 0

   // operation settings as last sent to the DUT
   logic [15:0]       m_add;
   logic              m_clamp;
   logic [7:0]        m_tv;
   logic [7:0]        m_tr;
   logic              m_tu;
   logic [7:0]        m_mv;

   image_proc_top UUT (
      .clk, .reset, .addr, .wr_en, .rd_en, .data_read, .data_read_valid, .data_write,
      .comm_cmd, .comm_data_in, .comm_data_in_valid, .comm_data_out,
      .comm_data_out_valid, .comm_data_out_free
   );

   image_proc_checker u_checker (
      .clk, .reset, .comm_data_out, .comm_data_out_valid, .exp_push, .exp_byte,
      .test_end, .test_id, .pending, .checked, .errors
   );

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0])
         return (s >> 1) ^ 32'h80200003;
      return s >> 1;
   endfunction

   task automatic take_bits(inout logic [31:0] st, input int n, output logic [15:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         st = lfsr_next(st);   // one step per bit
         v  = {v[14:0], st[0]};
      end
   endtask

   function automatic logic [7:0] saturate(input int v, input logic en, input logic [7:0] low);
      if (en && v > 255)
         return 8'hff;
      if (en && v < 0)
         return 8'h00;
      return low;
   endfunction

   // expected pixel from the operation rules
   function automatic logic [7:0] ref_pixel(input logic [1:0] op, input logic [7:0] p);
      logic [15:0] sum;
      logic [15:0] prod;
      logic [7:0]  r;
      sum  = {8'h00, p} + m_add;
      prod = {8'h00, p} * {8'h00, m_mv};
      case (op)
         OP_ADD:       r = saturate(int'($signed(sum)), m_clamp, sum[7:0]);
         OP_THRESHOLD: r = (m_tu ? (p >= m_tv) : (p <= m_tv)) ? m_tr : p;
         OP_INVERT:    r = ~p;
         default:      r = saturate(int'($signed(prod[15:4])), m_clamp, prod[11:4]);
      endcase
      return r;
   endfunction

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // random back-pressure on the output link
   initial begin
      logic [15:0] fbit;
      rng_free           = SEED;
      comm_data_out_free = 1'b1;
      forever begin
         @(posedge clk);
         #2;
         take_bits(rng_free, 1, fbit);
         comm_data_out_free = fbit[0];
      end
   end

   // memory model, one read in flight, 1 to 3 cycles of latency
   initial begin
      int          lat_left;
      logic [8:0]  pend;
      logic [15:0] lat;
      rng_mem         = SEED;
      lat_left        = 0;
      pend            = '0;
      data_read       = '0;
      data_read_valid = 1'b0;
      for (int i = 0; i < 512; i++)
         mem[i] = 16'(i * 257) ^ 16'h5aa5;
      forever begin
         @(posedge clk);
         #2;
         data_read_valid = 1'b0;
         if (wr_en)
            mem[addr[9:1]] = data_write;
         if (lat_left > 0) begin
            lat_left--;
            if (lat_left == 0) begin
               data_read       = mem[pend];
               data_read_valid = 1'b1;
            end
         end
         if (rd_en) begin
            pend = addr[9:1];
            take_bits(rng_mem, 2, lat);
            lat_left = int'(lat[1:0]) % 3 + 1;
         end
      end
   end

   task automatic link_write(input logic [7:0] cmd, input logic [7:0] data);
      @(posedge clk);
      #2;
      comm_cmd           = cmd;
      comm_data_in       = data;
      comm_data_in_valid = 1'b1;   // one-cycle strobe
      @(posedge clk);
      #2;
      comm_data_in_valid = 1'b0;
   endtask

   task automatic send_cmd(input logic [7:0] cmd);
      link_write(cmd, 8'h00);
   endtask

   task automatic send_data(input logic [7:0] data);
      link_write(8'h00, data);
   endtask

   task automatic push_expected(input logic [7:0] b);
      @(posedge clk);
      #2;
      exp_push = 1'b1;
      exp_byte = b;
   endtask

   task automatic push_done();
      @(posedge clk);
      #2;
      exp_push = 1'b0;
   endtask

   task automatic wait_output();
      int n;
      n = 0;
      while (pending != 0 && n < WAIT_LIMIT) begin
         @(posedge clk);
         #2;
         n++;
      end
      repeat (4) @(posedge clk);   // room for stray extra bytes
      #2;
   endtask

   task automatic wait_idle();
      @(posedge clk);
      #2;
      while (UUT.proc_busy) begin
         @(posedge clk);
         #2;
      end
   endtask

   task automatic finish_test(input logic [7:0] id);
      test_id  = id;
      test_end = 1'b1;
      @(posedge clk);
      #2;
      test_end = 1'b0;
      test_id  = id + 8'd1;   // tests run in numbered order
      tests_run++;
   endtask

   task automatic load_image();
      logic [15:0] v;
      send_cmd(CMD_SEND_IMG);
      for (int i = 0; i < PIXELS; i++) begin
         take_bits(rng_stim, 8, v);
         img[i] = v[7:0];
         send_data(v[7:0]);
      end
   endtask

   task automatic read_back(input logic [7:0] id);
      for (int i = 0; i < PIXELS; i++)
         push_expected(img[i]);
      push_done();
      send_cmd(CMD_READ_IMG);
      wait_output();
      finish_test(id);
   endtask

   task automatic expect_status(input logic busy);
      push_expected({STATUS_BYTE0[7:1], busy});
      push_expected(STATUS_BYTE1);
      push_expected(STATUS_BYTE2);
      push_expected(STATUS_BYTE3);
      push_done();
   endtask

   task automatic start_op(input logic [1:0] op);
      case (op)
         OP_ADD: begin
            send_cmd(CMD_APPLY_ADD);
            send_data(m_add[7:0]);
            send_data(m_add[15:8]);
            send_data({7'b0, m_clamp});
         end
         OP_THRESHOLD: begin
            send_cmd(CMD_APPLY_THRESHOLD);
            send_data(m_tv);
            send_data(m_tr);
            send_data({7'b0, m_tu});
         end
         OP_INVERT: send_cmd(CMD_APPLY_INVERT);
         default: begin
            send_cmd(CMD_APPLY_MULT);
            send_data(m_mv);
            send_data({7'b0, m_clamp});
         end
      endcase
   endtask

   // storage buffer holds the image between the two switches
   task automatic finish_op(input logic [1:0] op);
      wait_idle();
      for (int i = 0; i < PIXELS; i++)
         img[i] = ref_pixel(op, img[i]);
   endtask

   task automatic op_test(input logic [7:0] id, input logic [1:0] op);
      load_image();
      send_cmd(CMD_SWITCH_BUFFERS);
      start_op(op);
      finish_op(op);
      send_cmd(CMD_SWITCH_BUFFERS);
      read_back(id);
   endtask

   initial begin
      logic [15:0] v;
      reset              = 1'b1;
      comm_cmd           = 8'h00;
      comm_data_in       = 8'h00;
      comm_data_in_valid = 1'b0;
      exp_push           = 1'b0;
      exp_byte           = 8'h00;
      test_end           = 1'b0;
      test_id            = 8'd1;
      tests_run          = 0;
      rng_stim           = SEED;
      m_add              = '0;
      m_clamp            = 1'b0;
      m_tv               = 8'h00;
      m_tr               = 8'h00;
      m_tu               = 1'b0;
      m_mv               = 8'h00;
      repeat (5) @(posedge clk);
      #2;
      reset = 1'b0;

      send_cmd(CMD_PARAM);   // width, height, low byte first
      send_data(8'(WIDTH));
      send_data(8'(WIDTH >> 8));
      send_data(8'(HEIGHT));
      send_data(8'(HEIGHT >> 8));
      load_image();
      read_back(8'd1);

      expect_status(1'b0);
      send_cmd(CMD_GET_STATUS);
      wait_output();
      finish_test(8'd2);

      // status right behind an ADD sees busy, job works on the storage buffer
      m_add   = 16'd1;
      m_clamp = 1'b1;
      expect_status(1'b1);
      start_op(OP_ADD);
      send_cmd(CMD_GET_STATUS);
      wait_output();
      wait_idle();
      finish_test(8'd3);

      take_bits(rng_stim, 7, v);
      m_add = 16'h0080 | v;   // 128..255, most pixels overflow
      op_test(8'd4, OP_ADD);
      m_clamp = 1'b0;
      op_test(8'd5, OP_ADD);

      m_tv = 8'h80;
      m_tr = 8'h00;
      m_tu = 1'b1;
      op_test(8'd6, OP_THRESHOLD);
      m_tv = 8'h40;
      m_tr = 8'hff;
      m_tu = 1'b0;
      op_test(8'd7, OP_THRESHOLD);

      load_image();
      send_cmd(CMD_SWITCH_BUFFERS);
      start_op(OP_INVERT);
      finish_op(OP_INVERT);
      m_mv    = 8'd24;   // 1.5 in 4.4 fixed point
      m_clamp = 1'b1;
      start_op(OP_MULT);
      finish_op(OP_MULT);
      send_cmd(CMD_SWITCH_BUFFERS);
      read_back(8'd8);

      $display("%0d tests run, %0d bytes checked, %0d errors", tests_run, checked, errors);
      if (errors == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

   initial begin
      cycles = 0;
      while (cycles < CYCLE_LIMIT) begin
         @(posedge clk);
         cycles++;
      end
      $display("run stopped after %0d cycles without reaching the end of the tests", cycles);
      $display("Verification failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== all.f ====
design/img_pkg.sv
design/command_decoder.sv
design/memory_port.sv
design/pixel_op_unit.sv
design/pixel_processor.sv
design/image_streamer.sv
design/image_proc_top.sv
test/image_proc_checker.sv
test/tb_image_proc.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_image_proc
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Verification passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
